// ==== Bender.yml ====
package:
  name: bbc_mem

sources:
  - source/bbc_mem_pkg.sv
  - source/bbc_ctrl_pkg.sv
  - source/reset_sequencer.sv
  - source/rom_loader.sv
  - source/sdram_addr_map.sv
  - source/bbc_mem_top.sv
  - target: simulation
    files:
      - verif/bbc_mem_assertions.sv
      - verif/tb_bbc_mem_top.sv

// ==== compile.f ====
source/bbc_mem_pkg.sv
source/bbc_ctrl_pkg.sv
source/reset_sequencer.sv
source/rom_loader.sv
source/sdram_addr_map.sv
source/bbc_mem_top.sv
verif/bbc_mem_assertions.sv
verif/tb_bbc_mem_top.sv

// ==== source/bbc_ctrl_pkg.sv ====
`default_nettype none

package bbc_ctrl_pkg;

	// image index from the downloader
	typedef logic [7:0] ioctl_index_t;

	// this index routes the payload to the cmos ram
	localparam ioctl_index_t cmos_index = 8'hFF;

	// cmos ram holds 128 bytes
	localparam int cmos_addr_width = 7;

	typedef logic [cmos_addr_width-1:0] cmos_addr_t;

endpackage

`default_nettype wire

// ==== source/bbc_mem_pkg.sv ====
`default_nettype none

package bbc_mem_pkg;

	// 6502 bus address
	typedef logic [15:0] cpu_addr_t;

	// rom select register
	// bit 7 enables private ram, bits 3..0 pick the sideways bank
	typedef logic [7:0] romsel_t;

	// byte address into the sdram
	typedef logic [24:0] sdram_addr_t;

	typedef logic [7:0] byte_t;

	// download targets
	// index 0 carries the os roms, everything else lands in the alt area
	localparam sdram_addr_t rom_base_main = 25'h080000;
	localparam sdram_addr_t rom_base_alt = 25'h068000;

	// sdram memory map
	//   00000-07FFF main ram
	//   08000-08FFF private ram (master)
	//   0A000-0BFFF filing system ram (master)
	//   10000-17FFF shadow ram
	//   40000-7FFFF sideways ram
	//   80000-DFFFF roms

	// os12 at 80000, master mos one bank above
	localparam sdram_addr_t mos_rom_base = 25'h080000;

	// model b sideways roms, four banks of 16k
	localparam sdram_addr_t modelb_rom_base = 25'h090000;

	// master sideways roms, bank bits 3..2 select a 64k block
	localparam sdram_addr_t master_rom_base = 25'h0A0000;

	// 8k filing system ram behind acc_y
	localparam sdram_addr_t filing_ram_base = 25'h00A000;

	// 16 banks of 16k, only 4..7 are writable
	localparam sdram_addr_t sideways_ram_base = 25'h040000;

endpackage

`default_nettype wire

// ==== source/bbc_mem_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module bbc_mem_top #(
	parameter int unsigned autoboot_cycles = 32_000_000,
	parameter int unsigned remap_hold_cycles = 4095
) (
	input wire logic clk_48m,
	input wire logic reset,
	input wire logic mem_sync,
	input wire logic phi0,
	input wire bbc_mem_pkg::cpu_addr_t cpu_adr,
	input wire logic cpu_we,
	input wire bbc_mem_pkg::byte_t cpu_dout,
	input wire bbc_mem_pkg::romsel_t romsel,
	input wire logic acc_y,
	input wire logic shadow_ram,
	input wire logic shadow_vid,
	input wire logic model,
	input wire logic rom_map,
	input wire logic autoboot,
	input wire logic ioctl_download,
	input wire logic ioctl_wr,
	input wire bbc_mem_pkg::sdram_addr_t ioctl_addr,
	input wire bbc_mem_pkg::byte_t ioctl_dout,
	input wire bbc_ctrl_pkg::ioctl_index_t ioctl_index,
	output logic core_reset,
	output logic autoboot_shift,
	output bbc_mem_pkg::sdram_addr_t sdram_adr,
	output logic sdram_we,
	output bbc_mem_pkg::byte_t sdram_din,
	output logic cmos_we,
	output bbc_ctrl_pkg::cmos_addr_t cmos_addr,
	output bbc_mem_pkg::byte_t cmos_din
);

	import bbc_mem_pkg::*;

	// loader to address map
	logic loader_we;
	sdram_addr_t loader_addr;
	byte_t loader_data;

	reset_sequencer #(
		.autoboot_cycles(autoboot_cycles),
		.remap_hold_cycles(remap_hold_cycles)
	) i_reset_sequencer (
		.clk_48m(clk_48m),
		.reset(reset),
		.mem_sync(mem_sync),
		.ioctl_download(ioctl_download),
		.model(model),
		.rom_map(rom_map),
		.autoboot(autoboot),
		.core_reset(core_reset),
		.autoboot_shift(autoboot_shift)
	);

	rom_loader i_rom_loader (
		.clk_48m(clk_48m),
		.reset(reset),
		.mem_sync(mem_sync),
		.ioctl_download(ioctl_download),
		.ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.ioctl_index(ioctl_index),
		.loader_we(loader_we),
		.loader_addr(loader_addr),
		.loader_data(loader_data),
		.cmos_we(cmos_we),
		.cmos_addr(cmos_addr),
		.cmos_din(cmos_din)
	);

	sdram_addr_map i_sdram_addr_map (
		.ioctl_download(ioctl_download),
		.loader_we(loader_we),
		.loader_addr(loader_addr),
		.loader_data(loader_data),
		.phi0(phi0),
		.model(model),
		.rom_map(rom_map),
		.cpu_adr(cpu_adr),
		.cpu_we(cpu_we),
		.cpu_dout(cpu_dout),
		.romsel(romsel),
		.acc_y(acc_y),
		.shadow_ram(shadow_ram),
		.shadow_vid(shadow_vid),
		.sdram_adr(sdram_adr),
		.sdram_we(sdram_we),
		.sdram_din(sdram_din)
	);

endmodule

`default_nettype wire

// ==== source/reset_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module reset_sequencer #(
	parameter int unsigned autoboot_cycles = 32_000_000,
	parameter int unsigned remap_hold_cycles = 4095
) (
	input wire logic clk_48m,
	input wire logic reset,
	input wire logic mem_sync,
	input wire logic ioctl_download,
	input wire logic model,
	input wire logic rom_map,
	input wire logic autoboot,
	output logic core_reset,
	output logic autoboot_shift
);

	localparam int remap_width = $clog2(remap_hold_cycles + 1);
	localparam int autoboot_width = $clog2(autoboot_cycles + 1);

	logic last_model;
	logic last_rom_map;
	logic [remap_width-1:0] remap_cnt;
	logic [autoboot_width-1:0] autoboot_cnt;
	logic map_changed;
	logic reset_cause;

	// previous settings, only used for edge detection
	always_ff @(posedge clk_48m) begin
		last_model <= model;
		last_rom_map <= rom_map;
	end

	assign map_changed = (last_model != model) || (last_rom_map != rom_map);

	// hold the core in reset while the rom layout settles
	always_ff @(posedge clk_48m) begin
		if (reset) begin
			remap_cnt <= '0;
		end else if (map_changed) begin
			remap_cnt <= remap_width'(remap_hold_cycles);
		end else if (remap_cnt != '0) begin
			remap_cnt <= remap_cnt - 1'b1;
		end
	end

	assign reset_cause = reset || ioctl_download || (remap_cnt != '0);

	// sampled on the slot pulse so the cpu starts on a slot boundary
	always_ff @(posedge clk_48m) begin
		if (mem_sync) begin
			core_reset <= reset_cause;
		end
	end

	// shift is held after reset so the mos boots the disc
	always_ff @(posedge clk_48m) begin
		if (core_reset) begin
			autoboot_cnt <= autoboot_width'(autoboot_cycles);
		end else if (reset) begin
			autoboot_cnt <= '0;
		end else if (autoboot_cnt != '0) begin
			autoboot_cnt <= autoboot_cnt - 1'b1;
		end
	end

	assign autoboot_shift = autoboot && (autoboot_cnt != '0);

endmodule

`default_nettype wire

// ==== source/rom_loader.sv ====
`timescale 1ns/10ps
`default_nettype none

module rom_loader (
	input wire logic clk_48m,
	input wire logic reset,
	input wire logic mem_sync,
	input wire logic ioctl_download,
	input wire logic ioctl_wr,
	input wire bbc_mem_pkg::sdram_addr_t ioctl_addr,
	input wire bbc_mem_pkg::byte_t ioctl_dout,
	input wire bbc_ctrl_pkg::ioctl_index_t ioctl_index,
	output logic loader_we,
	output bbc_mem_pkg::sdram_addr_t loader_addr,
	output bbc_mem_pkg::byte_t loader_data,
	output logic cmos_we,
	output bbc_ctrl_pkg::cmos_addr_t cmos_addr,
	output bbc_mem_pkg::byte_t cmos_din
);

	import bbc_mem_pkg::*;
	import bbc_ctrl_pkg::*;

	logic pending;
	logic is_cmos;
	sdram_addr_t image_base;

	assign is_cmos = (ioctl_index == cmos_index);

	// os roms go to index 0, all other images to the alt area
	assign image_base = (ioctl_index == '0) ? rom_base_main : rom_base_alt;

	// one write per slot, a second one in the same slot is dropped
	always_ff @(posedge clk_48m) begin
		if (reset) begin
			pending <= 1'b0;
			loader_we <= 1'b0;
		end else begin
			if (mem_sync) begin
				pending <= 1'b0;
				loader_we <= pending;
			end
			// a strobe in the sync cycle itself wins over the clear
			if (ioctl_download && ioctl_wr && !is_cmos) begin
				pending <= 1'b1;
			end
		end
	end

	// source holds address and data until the slot opens
	always_ff @(posedge clk_48m) begin
		if (mem_sync && pending) begin
			loader_addr <= ioctl_addr + image_base;
			loader_data <= ioctl_dout;
		end
	end

	// cmos path bypasses the sdram slots
	assign cmos_we = ioctl_download && ioctl_wr && is_cmos;
	assign cmos_addr = ioctl_addr[cmos_addr_width-1:0];
	assign cmos_din = ioctl_dout;

endmodule

`default_nettype wire

// ==== source/sdram_addr_map.sv ====
`timescale 1ns/10ps
`default_nettype none

module sdram_addr_map (
	input wire logic ioctl_download,
	input wire logic loader_we,
	input wire bbc_mem_pkg::sdram_addr_t loader_addr,
	input wire bbc_mem_pkg::byte_t loader_data,
	input wire logic phi0,
	input wire logic model,
	input wire logic rom_map,
	input wire bbc_mem_pkg::cpu_addr_t cpu_adr,
	input wire logic cpu_we,
	input wire bbc_mem_pkg::byte_t cpu_dout,
	input wire bbc_mem_pkg::romsel_t romsel,
	input wire logic acc_y,
	input wire logic shadow_ram,
	input wire logic shadow_vid,
	output bbc_mem_pkg::sdram_addr_t sdram_adr,
	output logic sdram_we,
	output bbc_mem_pkg::byte_t sdram_din
);

	import bbc_mem_pkg::*;

	logic cpu_ram;
	logic sideways;
	logic mos_rom;
	logic mos_ram;
	logic filing_ram;
	logic sideways_ram;
	logic sideways_rom_master;
	logic sideways_rom_modelb;
	logic [1:0] bank_hi;
	sdram_addr_t bank_offset;
	sdram_addr_t modelb_offset;

	assign bank_hi = romsel[3:2];

	// cpu region decode
	assign cpu_ram = !cpu_adr[15];
	assign sideways = (cpu_adr[15:14] == 2'b10);
	assign mos_rom = (cpu_adr[15:14] == 2'b11);
	// 8000-8FFF private ram when romsel bit 7 is set
	assign mos_ram = sideways && (cpu_adr[13:12] == 2'b00) && romsel[7];
	// C000-DFFF filing system ram
	assign filing_ram = (cpu_adr[15:13] == 3'b110) && acc_y;

	// banks 4 to 7 are ram
	assign sideways_ram = sideways && (bank_hi == 2'b01);

	// master has roms in 0-3 and 8-F
	assign sideways_rom_master = sideways && ((bank_hi == 2'b00) || romsel[3]);
	// model b, rom_map high puts the four roms in 0-3
	assign sideways_rom_modelb = sideways && (rom_map ? (bank_hi == 2'b00) : (bank_hi == 2'b11));

	// 16k page offsets within the rom and ram areas
	assign bank_offset = sdram_addr_t'({romsel[3:0], cpu_adr[13:0]});
	assign modelb_offset = sdram_addr_t'({romsel[1:0], cpu_adr[13:0]});

	always_comb begin
		if (ioctl_download) begin
			sdram_adr = loader_addr;
		end else if (!phi0) begin
			// video fetch
			sdram_adr = sdram_addr_t'({shadow_vid, cpu_adr});
		end else if (cpu_ram || mos_ram) begin
			sdram_adr = sdram_addr_t'({shadow_ram, cpu_adr});
		end else if (filing_ram) begin
			sdram_adr = filing_ram_base + sdram_addr_t'(cpu_adr[12:0]);
		end else if (mos_rom) begin
			// os12 or master mos
			sdram_adr = mos_rom_base + sdram_addr_t'({model, cpu_adr[13:0]});
		end else if (sideways_rom_modelb && !model) begin
			sdram_adr = modelb_rom_base + modelb_offset;
		end else if (sideways_rom_master && model) begin
			sdram_adr = master_rom_base + bank_offset;
		end else begin
			sdram_adr = sideways_ram_base + bank_offset;
		end
	end

	// roms are never written from the cpu side
	assign sdram_we = ioctl_download ? loader_we
		: (cpu_we && (cpu_ram || sideways_ram || mos_ram || filing_ram));

	assign sdram_din = ioctl_download ? loader_data : cpu_dout;

endmodule

`default_nettype wire

// ==== verif/bbc_mem_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module bbc_mem_assertions (
	input wire logic clk_48m,
	input wire logic reset,
	input wire logic mem_sync,
	input wire logic ioctl_download,
	input wire logic autoboot,
	input wire logic core_reset,
	input wire logic autoboot_shift,
	input wire logic sdram_we
);

	int error_count = 0;

	// core reset only moves in the cycle after a slot pulse
	core_reset_on_slot: assert property (@(posedge clk_48m) disable iff (reset)
		$changed(core_reset) |-> $past(mem_sync))
		else begin
			$error("core_reset changed outside a mem_sync slot");
			error_count++;
		end

	// loader writes open and close on slot boundaries
	loader_we_on_slot: assert property (@(posedge clk_48m) disable iff (reset)
		ioctl_download && $past(ioctl_download) && $changed(sdram_we) |-> $past(mem_sync))
		else begin
			$error("sdram_we changed outside a mem_sync slot during download");
			error_count++;
		end

	core_reset_held: assert property (@(posedge clk_48m)
		(reset || ioctl_download) && mem_sync |=> core_reset)
		else begin
			$error("core_reset low while reset or download was active");
			error_count++;
		end

	core_reset_release: assert property (@(posedge clk_48m)
		$fell(core_reset) |-> !$past(reset) && !$past(ioctl_download))
		else begin
			$error("core_reset fell before reset and download had ended");
			error_count++;
		end

	// shift starts with the core reset
	shift_follows_reset: assert property (@(posedge clk_48m) disable iff (reset)
		core_reset |=> (autoboot_shift || !autoboot))
		else begin
			$error("autoboot_shift not raised during core reset");
			error_count++;
		end

endmodule

`default_nettype wire

// ==== verif/tb_bbc_mem_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_bbc_mem_top;

	import bbc_mem_pkg::*;
	import bbc_ctrl_pkg::*;

	localparam int autoboot_len = 64;
	localparam int remap_hold = 16;
	// upper bound on the run length
	localparam int max_cycles = 3000;

	logic clk_48m = 1'b0;
	logic reset;
	logic mem_sync = 1'b1;
	logic phi0;
	cpu_addr_t cpu_adr;
	logic cpu_we;
	byte_t cpu_dout;
	romsel_t romsel;
	logic acc_y;
	logic shadow_ram;
	logic shadow_vid;
	logic model;
	logic rom_map;
	logic autoboot;
	logic ioctl_download;
	logic ioctl_wr;
	sdram_addr_t ioctl_addr;
	byte_t ioctl_dout;
	ioctl_index_t ioctl_index;
	logic core_reset;
	logic autoboot_shift;
	sdram_addr_t sdram_adr;
	logic sdram_we;
	byte_t sdram_din;
	logic cmos_we;
	cmos_addr_t cmos_addr;
	byte_t cmos_din;
	logic [15:0] lfsr_state = 16'd59;
	int cycle_count = 0;

	bbc_mem_top #(
		.autoboot_cycles(autoboot_len),
		.remap_hold_cycles(remap_hold)
	) i_dut (.*);

	bind bbc_mem_top bbc_mem_assertions i_assertions (
		.clk_48m(clk_48m),
		.reset(reset),
		.mem_sync(mem_sync),
		.ioctl_download(ioctl_download),
		.autoboot(autoboot),
		.core_reset(core_reset),
		.autoboot_shift(autoboot_shift),
		.sdram_we(sdram_we)
	);

	always #20 clk_48m = !clk_48m;

	// slot pulse every fourth cycle and the run limit
	always @(negedge clk_48m) begin
		cycle_count <= cycle_count + 1;
		mem_sync <= (cycle_count % 4 == 3);
		if (cycle_count >= max_cycles) begin
			abort_run("timeout: run exceeded the cycle limit");
		end else if (i_dut.i_assertions.error_count != 0) begin
			abort_run("a bound assertion failed");
		end
	end

	task automatic abort_run(input string why);
		if (why != "") begin
			$display("%s", why);
		end
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			abort_run("");
		end
	endtask

	// galois lfsr stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
		end
		return val;
	endfunction

	// reference for the ordered address rules
	task automatic check_map();
		sdram_addr_t exp_adr;
		sdram_addr_t low14;
		logic exp_we;
		logic [3:0] bank;
		logic sw_area;
		logic mos_ram_hit;
		logic filing_hit;
		logic swram_hit;
		bank = romsel[3:0];
		low14 = sdram_addr_t'(cpu_adr[13:0]);
		sw_area = (cpu_adr >= 16'h8000) && (cpu_adr <= 16'hBFFF);
		mos_ram_hit = (cpu_adr >= 16'h8000) && (cpu_adr <= 16'h8FFF) && romsel[7];
		filing_hit = (cpu_adr >= 16'hC000) && (cpu_adr <= 16'hDFFF) && acc_y;
		swram_hit = sw_area && (bank[3:2] == 2'b01);
		if (!phi0) begin
			exp_adr = sdram_addr_t'(shadow_vid) * 25'h10000 + sdram_addr_t'(cpu_adr);
		end else if (!cpu_adr[15] || mos_ram_hit) begin
			exp_adr = sdram_addr_t'(shadow_ram) * 25'h10000 + sdram_addr_t'(cpu_adr);
		end else if (filing_hit) begin
			exp_adr = filing_ram_base + sdram_addr_t'(cpu_adr[12:0]);
		end else if (cpu_adr >= 16'hC000) begin
			exp_adr = mos_rom_base + sdram_addr_t'(model) * 25'h4000 + low14;
		end else if (!model && (rom_map ? bank[3:2] == 2'b00 : bank[3:2] == 2'b11)) begin
			exp_adr = modelb_rom_base + sdram_addr_t'(bank[1:0]) * 25'h4000 + low14;
		end else if (model && (bank[3:2] == 2'b00 || bank[3])) begin
			exp_adr = master_rom_base + sdram_addr_t'(bank[3:2]) * 25'h10000
				+ sdram_addr_t'(bank[1:0]) * 25'h4000 + low14;
		end else begin
			exp_adr = sideways_ram_base + sdram_addr_t'(bank) * 25'h4000 + low14;
		end
		exp_we = cpu_we && (!cpu_adr[15] || swram_hit || mos_ram_hit || filing_hit);
		check_value("sdram_adr", 32'(sdram_adr), 32'(exp_adr));
		check_value("sdram_we", 32'(sdram_we), 32'(exp_we));
		check_value("sdram_din", 32'(sdram_din), 32'(cpu_dout));
	endtask

	task automatic wait_reset_release(input int limit);
		int waited;
		waited = 0;
		@(posedge clk_48m);
		while (core_reset && waited < limit) begin
			waited++;
			@(posedge clk_48m);
		end
		assert (!core_reset) else abort_run("core_reset did not fall after its causes ended");
	endtask

	task automatic loader_write(input ioctl_index_t idx, input sdram_addr_t addr,
		input byte_t data);
		sdram_addr_t exp_adr;
		int waited;
		int high;
		exp_adr = addr + ((idx == 8'h00) ? rom_base_main : rom_base_alt);
		@(negedge clk_48m);
		ioctl_index = idx;
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr = 1'b1;
		@(negedge clk_48m);
		ioctl_wr = 1'b0;
		waited = 0;
		@(posedge clk_48m);
		while (!sdram_we && waited < 12) begin
			waited++;
			@(posedge clk_48m);
		end
		assert (sdram_we) else abort_run("loader write never reached a memory slot");
		check_value("sdram_adr", 32'(sdram_adr), 32'(exp_adr));
		check_value("sdram_din", 32'(sdram_din), 32'(data));
		high = 0;
		while (sdram_we && high < 12) begin
			high++;
			@(posedge clk_48m);
		end
		// one slot is four cycles
		check_value("sdram_we high cycles", 32'(high), 32'd4);
		repeat (8) begin
			assert (!sdram_we) else abort_run("sdram_we rose again without a new write");
			@(posedge clk_48m);
		end
	endtask

	task automatic cmos_write(input sdram_addr_t addr, input byte_t data);
		@(negedge clk_48m);
		ioctl_index = cmos_index;
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr = 1'b1;
		@(posedge clk_48m);
		check_value("cmos_we", 32'(cmos_we), 32'd1);
		check_value("cmos_addr", 32'(cmos_addr), 32'(addr % 128));
		check_value("cmos_din", 32'(cmos_din), 32'(data));
		@(negedge clk_48m);
		ioctl_wr = 1'b0;
		repeat (8) begin
			@(posedge clk_48m);
			assert (!sdram_we && !cmos_we) else abort_run("cmos write leaked into a memory slot");
		end
	endtask

	task automatic remap_check(input logic toggle_rom_map);
		int k;
		int exp_fall;
		logic seen_high;
		@(negedge clk_48m);
		if (toggle_rom_map) begin
			rom_map = !rom_map;
		end else begin
			model = !model;
		end
		exp_fall = -1;
		seen_high = 1'b0;
		// edge 0 is the first rising edge after the toggle
		for (k = 0; k < 40; k++) begin
			@(posedge clk_48m);
			if (seen_high && !core_reset) begin
				break;
			end
			seen_high = seen_high || core_reset;
			if (exp_fall < 0 && mem_sync && k >= remap_hold + 1) begin
				exp_fall = k;
			end
		end
		assert (seen_high) else abort_run("core_reset never rose after a mapping change");
		check_value("core_reset fall edge", 32'(k - 1), 32'(exp_fall));
	endtask

	task automatic autoboot_check(input logic enable);
		int high;
		@(negedge clk_48m);
		autoboot = enable;
		reset = 1'b1;
		repeat (3) @(negedge clk_48m);
		reset = 1'b0;
		wait_reset_release(12);
		high = 0;
		while (autoboot_shift && high < autoboot_len + 8) begin
			high++;
			@(posedge clk_48m);
		end
		check_value("autoboot_shift high cycles", 32'(high), enable ? autoboot_len : 0);
	endtask

	initial begin
		reset = 1'b1;
		phi0 = 1'b1;
		cpu_adr = '0;
		cpu_we = 1'b0;
		cpu_dout = '0;
		romsel = '0;
		acc_y = 1'b0;
		shadow_ram = 1'b0;
		shadow_vid = 1'b0;
		model = 1'b0;
		rom_map = 1'b0;
		autoboot = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_index = '0;
		repeat (3) @(negedge clk_48m);
		reset = 1'b0;
		wait_reset_release(12);

		// random cpu and video accesses
		for (int n = 0; n < 300; n++) begin
			@(negedge clk_48m);
			cpu_adr = cpu_addr_t'(rand_bits(16));
			romsel = romsel_t'(rand_bits(8));
			cpu_dout = byte_t'(rand_bits(8));
			cpu_we = 1'(rand_bits(1));
			phi0 = (rand_bits(2) != 0);
			acc_y = 1'(rand_bits(1));
			shadow_ram = 1'(rand_bits(1));
			shadow_vid = 1'(rand_bits(1));
			model = 1'(rand_bits(1));
			rom_map = 1'(rand_bits(1));
			@(posedge clk_48m);
			check_map();
		end
		@(negedge clk_48m);
		cpu_we = 1'b0;
		phi0 = 1'b1;
		model = 1'b0;
		rom_map = 1'b0;
		wait_reset_release(40);

		// rom images then cmos bytes
		@(negedge clk_48m);
		ioctl_download = 1'b1;
		for (int n = 0; n < 8; n++) begin
			loader_write((n % 2 == 0) ? 8'h00 : ioctl_index_t'(rand_bits(7) + 1),
				sdram_addr_t'(rand_bits(18)), byte_t'(rand_bits(8)));
		end
		for (int n = 0; n < 4; n++) begin
			cmos_write(sdram_addr_t'(rand_bits(10)), byte_t'(rand_bits(8)));
		end
		@(negedge clk_48m);
		ioctl_download = 1'b0;
		wait_reset_release(12);

		remap_check(1'b0);
		remap_check(1'b1);
		remap_check(1'b0);
		autoboot_check(1'b1);
		autoboot_check(1'b0);

		if (i_dut.i_assertions.error_count == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			abort_run("a bound assertion failed");
		end
	end

endmodule

`default_nettype wire
